//--- Bender.yml
package:
  name: msx_cas_buffer

sources:
  - design/msx_buf_pkg.sv
  - design/pack_loader.sv
  - design/cas_player.sv
  - design/buffer_arbiter.sv
  - design/msx_cas_buffer.sv
  - target: simulation
    files:
      - dv/buffer_mem_model.sv
      - dv/msx_cas_buffer_tb.sv

//--- design/buffer_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter (
   input  logic                  clk21m,
   input  logic                  rst,
   input  logic                  pack_busy,
   input  msx_buf_pkg::buf_req_t ld_req,
   output msx_buf_pkg::buf_rsp_t ld_rsp,
   input  msx_buf_pkg::buf_req_t cas_req,
   output msx_buf_pkg::buf_rsp_t cas_rsp,
   output msx_buf_pkg::buf_req_t mem_req,
   input  msx_buf_pkg::buf_rsp_t mem_rsp
);

   import msx_buf_pkg::*;

   logic                  ld_pend_q;
   logic                  cas_pend_q;
   logic [BUF_ADDR_W-1:0] ld_addr_q;
   logic [BUF_ADDR_W-1:0] cas_addr_q;
   logic [BUF_ADDR_W-1:0] ld_addr;
   logic [BUF_ADDR_W-1:0] cas_addr;
   logic                  ld_want;
   logic                  cas_want;
   logic                  grant_ld;
   logic                  grant_cas;
   logic                  busy_q;
   logic                  owner_cas_q;
   logic                  rd_q;
   logic [BUF_ADDR_W-1:0] addr_q;

   // ====================
   // Request side
   // ====================

   // New rd this cycle or one held from earlier
   assign ld_want   = ld_pend_q || ld_req.rd;
   // Tape locked out for the whole pack copy
   assign cas_want  = (cas_pend_q || cas_req.rd) && !pack_busy;
   // Loader first
   assign grant_ld  = !busy_q && ld_want;
   assign grant_cas = !busy_q && !ld_want && cas_want;

   // Address from the live request or the held copy
   assign ld_addr   = ld_req.rd ? ld_req.addr : ld_addr_q;
   assign cas_addr  = cas_req.rd ? cas_req.addr : cas_addr_q;

   always_ff @(posedge clk21m) begin
      if (rst) begin
         ld_pend_q   <= 1'b0;
         cas_pend_q  <= 1'b0;
         busy_q      <= 1'b0;
         owner_cas_q <= 1'b0;
         rd_q        <= 1'b0;
      end else begin
         ld_pend_q  <= ld_want && !grant_ld;
         cas_pend_q <= (cas_pend_q || cas_req.rd) && !grant_cas;
         // One registered cycle to the port
         rd_q       <= grant_ld || grant_cas;
         if (busy_q && mem_rsp.ready) begin
            busy_q <= 1'b0;
         end else if (grant_ld || grant_cas) begin
            busy_q      <= 1'b1;
            owner_cas_q <= grant_cas;
         end
      end
   end

   // Held addresses and port address
   always_ff @(posedge clk21m) begin
      if (ld_req.rd) begin
         ld_addr_q <= ld_req.addr;
      end
      if (cas_req.rd) begin
         cas_addr_q <= cas_req.addr;
      end
      if (grant_ld) begin
         addr_q <= ld_addr;
      end else if (grant_cas) begin
         addr_q <= cas_addr;
      end
   end

   assign mem_req = '{rd: rd_q, addr: addr_q};

   // ====================
   // Response side
   // ====================

   // Ready only to the owner, no added latency
   assign ld_rsp  = '{ready: mem_rsp.ready && busy_q && !owner_cas_q, data: mem_rsp.data};
   assign cas_rsp = '{ready: mem_rsp.ready && busy_q && owner_cas_q, data: mem_rsp.data};

   // Memory answers only reads it was given
   a_rsp_when_busy: assert property (@(posedge clk21m) disable iff (rst)
      mem_rsp.ready |-> busy_q);

   // Single outstanding read on the port
   a_single_outstanding: assert property (@(posedge clk21m) disable iff (rst)
      mem_req.rd |=> (!mem_req.rd until mem_rsp.ready));

endmodule

`default_nettype wire

//--- design/cas_player.sv
`timescale 1ns/1ps
`default_nettype none

module cas_player #(
   parameter logic [msx_buf_pkg::BUF_ADDR_W-1:0] CAS_BASE = 28'h1400000,
   parameter int                                 BIT_DIV  = 8
) (
   input  logic                          clk21m,
   input  logic                          rst,
   input  logic                          play,
   input  logic                          rewind,
   input  logic [msx_buf_pkg::LEN_W-1:0] cas_len,
   output msx_buf_pkg::buf_req_t         req,
   input  msx_buf_pkg::buf_rsp_t         rsp,
   output msx_buf_pkg::tape_out_t        tape
);

   import msx_buf_pkg::*;

   // Bit timer range 0..BIT_DIV-1
   localparam int               CNT_W   = $clog2(BIT_DIV + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(BIT_DIV - 1);

   logic [LEN_W-1:0]      idx_q;
   logic                  rd_q;
   logic [BUF_ADDR_W-1:0] rd_addr_q;
   logic                  pend_q;
   logic                  drop_q;
   logic                  hold_full_q;
   logic [DATA_W-1:0]     hold_q;
   logic [DATA_W-1:0]     sh_q;
   logic [3:0]            bits_q;
   logic [CNT_W-1:0]      cnt_q;
   logic                  eot_q;
   logic                  bit_valid_q;
   logic                  bit_val_q;
   logic                  fetch;
   logic                  tick;
   logic                  from_sh;
   logic                  from_hold;
   logic                  drained;
   logic                  rsp_keep;

   // Prefetch when holding register empty and bytes remain
   assign fetch     = !hold_full_q && !pend_q && (idx_q < cas_len);
   // Bit slot reached only while playing
   assign tick      = play && !eot_q && (cnt_q == CNT_MAX);
   assign from_sh   = tick && (bits_q != 4'd0);
   assign from_hold = tick && (bits_q == 4'd0) && hold_full_q;
   // Nothing left anywhere in the pipe
   assign drained   = (bits_q == 4'd0) && !hold_full_q && !pend_q && (idx_q >= cas_len);
   // Responses in flight across a rewind are thrown away
   assign rsp_keep  = rsp.ready && pend_q && !drop_q;

   // ====================
   // Fetch and bit control
   // ====================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         idx_q       <= '0;
         rd_q        <= 1'b0;
         pend_q      <= 1'b0;
         drop_q      <= 1'b0;
         hold_full_q <= 1'b0;
         bits_q      <= 4'd0;
         cnt_q       <= '0;
         eot_q       <= 1'b0;
         bit_valid_q <= 1'b0;
      end else if (rewind) begin
         idx_q       <= '0;
         rd_q        <= 1'b0;
         // Keep tracking a read still in flight but mark it stale
         pend_q      <= pend_q && !rsp.ready;
         drop_q      <= pend_q && !rsp.ready;
         hold_full_q <= 1'b0;
         bits_q      <= 4'd0;
         cnt_q       <= '0;
         eot_q       <= 1'b0;
         bit_valid_q <= 1'b0;
      end else begin
         rd_q        <= 1'b0;
         bit_valid_q <= 1'b0;

         if (fetch) begin
            rd_q   <= 1'b1;
            pend_q <= 1'b1;
            idx_q  <= idx_q + 1'b1;
         end
         if (rsp.ready && pend_q) begin
            pend_q <= 1'b0;
            drop_q <= 1'b0;
         end

         // Holding register
         if (rsp_keep) begin
            hold_full_q <= 1'b1;
         end
         if (from_hold) begin
            hold_full_q <= 1'b0;
         end

         // Bits left in shift register
         if (from_sh) begin
            bits_q <= bits_q - 4'd1;
         end
         if (from_hold) begin
            bits_q <= 4'd7;
         end
         if (from_sh || from_hold) begin
            bit_valid_q <= 1'b1;
         end

         // Level held until rewind
         if (tick && drained) begin
            eot_q <= 1'b1;
         end

         // Timer waits at max when no bit is ready yet
         if (play && !eot_q && (cnt_q != CNT_MAX)) begin
            cnt_q <= cnt_q + 1'b1;
         end else if (from_sh || from_hold) begin
            cnt_q <= '0;
         end
      end
   end

   // Payload registers
   always_ff @(posedge clk21m) begin
      if (fetch) begin
         rd_addr_q <= CAS_BASE + BUF_ADDR_W'(idx_q);
      end
      if (rsp_keep) begin
         hold_q <= rsp.data;
      end
      // MSB first
      if (from_sh) begin
         bit_val_q <= sh_q[7];
         sh_q      <= {sh_q[6:0], 1'b0};
      end else if (from_hold) begin
         bit_val_q <= hold_q[7];
         sh_q      <= {hold_q[6:0], 1'b0};
      end
   end

   assign req  = '{rd: rd_q, addr: rd_addr_q};
   assign tape = '{bit_valid: bit_valid_q, bit_val: bit_val_q, end_of_tape: eot_q};

   // No bit pulse while the tape sits at its end
   a_no_bit_after_eot: assert property (@(posedge clk21m) disable iff (rst)
      tape.bit_valid |-> !tape.end_of_tape);

endmodule

`default_nettype wire

//--- design/msx_buf_pkg.sv
`default_nettype none

package msx_buf_pkg;

   // ====================
   // Widths
   // ====================

   // Byte address into the DDR3 buffer
   localparam int BUF_ADDR_W = 28;
   // Byte address into system RAM
   localparam int RAM_ADDR_W = 27;
   // Image length in bytes
   localparam int LEN_W      = 24;
   // Buffer and RAM are byte wide
   localparam int DATA_W     = 8;

   // ====================
   // Bus types
   // ====================

   // Read request toward the buffer, rd is a one-cycle pulse
   typedef struct packed {
      logic                  rd;
      logic [BUF_ADDR_W-1:0] addr;
   } buf_req_t;

   // Read response, data valid only while ready is high
   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] data;
   } buf_rsp_t;

   // Byte write into system RAM
   typedef struct packed {
      logic                  we;
      logic [RAM_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } ram_wr_t;

   // Serial tape stream from the cassette player
   typedef struct packed {
      logic bit_valid;
      logic bit_val;
      logic end_of_tape;
   } tape_out_t;

endpackage

`default_nettype wire

//--- design/msx_cas_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module msx_cas_buffer #(
   parameter logic [msx_buf_pkg::BUF_ADDR_W-1:0] PACK_BASE = 28'h0000000,
   parameter logic [msx_buf_pkg::BUF_ADDR_W-1:0] CAS_BASE  = 28'h1400000,
   parameter int                                 BIT_DIV   = 8
) (
   input  logic                          clk21m,
   input  logic                          rst,
   input  logic                          dl_start,
   input  logic [msx_buf_pkg::LEN_W-1:0] dl_len,
   input  logic                          play,
   input  logic                          rewind,
   input  logic [msx_buf_pkg::LEN_W-1:0] cas_len,
   output msx_buf_pkg::buf_req_t         mem_req,
   input  msx_buf_pkg::buf_rsp_t         mem_rsp,
   output msx_buf_pkg::ram_wr_t          ram_wr,
   output logic                          load_done,
   output logic                          reset_rq,
   output msx_buf_pkg::tape_out_t        tape
);

   import msx_buf_pkg::*;

   // Client side of the shared buffer port
   buf_req_t ld_req;
   buf_rsp_t ld_rsp;
   buf_req_t cas_req;
   buf_rsp_t cas_rsp;
   logic     pack_busy;

   // ====================
   // ROM pack loader
   // ====================
   pack_loader #(
      .PACK_BASE (PACK_BASE)
   ) i_pack_loader (
      .clk21m    (clk21m),
      .rst       (rst),
      .dl_start  (dl_start),
      .dl_len    (dl_len),
      .pack_busy (pack_busy),
      .req       (ld_req),
      .rsp       (ld_rsp),
      .ram_wr    (ram_wr),
      .load_done (load_done),
      .reset_rq  (reset_rq)
   );

   // ====================
   // Cassette player
   // ====================
   cas_player #(
      .CAS_BASE (CAS_BASE),
      .BIT_DIV  (BIT_DIV)
   ) i_cas_player (
      .clk21m  (clk21m),
      .rst     (rst),
      .play    (play),
      .rewind  (rewind),
      .cas_len (cas_len),
      .req     (cas_req),
      .rsp     (cas_rsp),
      .tape    (tape)
   );

   // ====================
   // Port arbiter
   // ====================
   buffer_arbiter i_buffer_arbiter (
      .clk21m    (clk21m),
      .rst       (rst),
      .pack_busy (pack_busy),
      .ld_req    (ld_req),
      .ld_rsp    (ld_rsp),
      .cas_req   (cas_req),
      .cas_rsp   (cas_rsp),
      .mem_req   (mem_req),
      .mem_rsp   (mem_rsp)
   );

endmodule

`default_nettype wire

//--- design/pack_loader.sv
`timescale 1ns/1ps
`default_nettype none

module pack_loader #(
   parameter logic [msx_buf_pkg::BUF_ADDR_W-1:0] PACK_BASE = 28'h0000000
) (
   input  logic                          clk21m,
   input  logic                          rst,
   input  logic                          dl_start,
   input  logic [msx_buf_pkg::LEN_W-1:0] dl_len,
   output logic                          pack_busy,
   output msx_buf_pkg::buf_req_t         req,
   input  msx_buf_pkg::buf_rsp_t         rsp,
   output msx_buf_pkg::ram_wr_t          ram_wr,
   output logic                          load_done,
   output logic                          reset_rq
);

   import msx_buf_pkg::*;

   logic [LEN_W-1:0]      len_q;
   logic [LEN_W-1:0]      idx_q;
   logic [LEN_W-1:0]      idx_nxt;
   logic                  rd_q;
   logic [BUF_ADDR_W-1:0] rd_addr_q;
   logic                  wait_q;
   logic                  done_pend_q;
   logic                  we_q;
   logic [RAM_ADDR_W-1:0] wr_addr_q;
   logic [DATA_W-1:0]     wr_data_q;
   logic                  start;
   logic                  rsp_hit;

   // New copy only when idle
   assign start   = dl_start && !pack_busy;
   // Byte for our outstanding read
   assign rsp_hit = wait_q && rsp.ready;
   assign idx_nxt = idx_q + 1'b1;

   // ====================
   // Copy control
   // ====================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         pack_busy   <= 1'b0;
         rd_q        <= 1'b0;
         wait_q      <= 1'b0;
         done_pend_q <= 1'b0;
         we_q        <= 1'b0;
         load_done   <= 1'b0;
         reset_rq    <= 1'b0;
         idx_q       <= '0;
         len_q       <= '0;
      end else begin
         // Pulses by default
         rd_q        <= 1'b0;
         we_q        <= 1'b0;
         done_pend_q <= 1'b0;
         // Done and reset request one cycle after last write
         load_done   <= done_pend_q;
         reset_rq    <= done_pend_q;
         if (done_pend_q) begin
            pack_busy <= 1'b0;
         end

         if (start) begin
            idx_q <= '0;
            len_q <= dl_len;
            // Empty image finishes without any read
            if (dl_len == '0) begin
               done_pend_q <= 1'b1;
            end else begin
               pack_busy <= 1'b1;
               rd_q      <= 1'b1;
               wait_q    <= 1'b1;
            end
         end

         if (rsp_hit) begin
            wait_q <= 1'b0;
            we_q   <= 1'b1;
            idx_q  <= idx_nxt;
            if (idx_nxt == len_q) begin
               done_pend_q <= 1'b1;
            end else begin
               // Next byte right after this one lands
               rd_q   <= 1'b1;
               wait_q <= 1'b1;
            end
         end
      end
   end

   // Address and write payload
   always_ff @(posedge clk21m) begin
      if (start) begin
         rd_addr_q <= PACK_BASE;
      end else if (rsp_hit) begin
         rd_addr_q <= PACK_BASE + BUF_ADDR_W'(idx_nxt);
      end
      if (rsp_hit) begin
         wr_addr_q <= RAM_ADDR_W'(idx_q);
         wr_data_q <= rsp.data;
      end
   end

   assign req    = '{rd: rd_q, addr: rd_addr_q};
   assign ram_wr = '{we: we_q, addr: wr_addr_q, data: wr_data_q};

   // No second read before the arbiter returns the first one
   a_one_outstanding: assert property (@(posedge clk21m) disable iff (rst)
      req.rd |=> (!req.rd until rsp.ready));

endmodule

`default_nettype wire

//--- dv/buffer_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_mem_model #(
   parameter int MAX_LAT = 6
) (
   input  logic                  clk21m,
   input  logic                  rst,
   input  msx_buf_pkg::buf_req_t req,
   output msx_buf_pkg::buf_rsp_t rsp,
   output logic                  overlap_err
);

   import msx_buf_pkg::*;

   // Sparse byte store, only the image regions get filled
   logic [DATA_W-1:0]     mem [logic [BUF_ADDR_W-1:0]];
   logic                  busy_q;
   logic [BUF_ADDR_W-1:0] addr_q;
   int unsigned           wait_q;
   logic                  rdy_q;
   logic [DATA_W-1:0]     data_q;

   // Backdoor fill from the testbench
   task automatic load_byte(input logic [BUF_ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      mem[a] = d;
   endtask

   // ====================
   // Read port
   // ====================
   always @(posedge clk21m) begin
      if (rst) begin
         busy_q      <= 1'b0;
         rdy_q       <= 1'b0;
         data_q      <= '0;
         wait_q      <= 0;
         overlap_err <= 1'b0;
      end else begin
         rdy_q <= 1'b0;
         // Count down the latency, ready pulse on the last cycle
         if (busy_q) begin
            if (wait_q <= 1) begin
               rdy_q  <= 1'b1;
               data_q <= mem.exists(addr_q) ? mem[addr_q] : 8'h00;
               busy_q <= 1'b0;
            end else begin
               wait_q <= wait_q - 1;
            end
         end
         if (req.rd) begin
            // Port takes one read at a time
            assert (!busy_q) else begin
               $display("Buffer memory got a read at %0t while another one was outstanding",
                        $time);
               overlap_err <= 1'b1;
            end
            busy_q <= 1'b1;
            addr_q <= req.addr;
            wait_q <= $urandom_range(MAX_LAT, 1);
         end
      end
   end

   assign rsp = '{ready: rdy_q, data: data_q};

endmodule

`default_nettype wire

//--- dv/msx_cas_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module msx_cas_buffer_tb;

   import msx_buf_pkg::*;

   localparam logic [BUF_ADDR_W-1:0] PACK_BASE    = 28'h0000000;
   localparam logic [BUF_ADDR_W-1:0] CAS_BASE     = 28'h1400000;
   localparam int                    BIT_DIV      = 8;
   localparam int                    CYC_PER_BYTE = BIT_DIV * 8 + 16;
   localparam int                    PACK_MAX     = 64;
   localparam int                    CAS_MAX      = 32;

   logic             clk21m;
   logic             rst;
   logic             dl_start;
   logic [LEN_W-1:0] dl_len;
   logic             play;
   logic             rewind;
   logic [LEN_W-1:0] cas_len;
   buf_req_t         mem_req;
   buf_rsp_t         mem_rsp;
   ram_wr_t          ram_wr;
   logic             load_done;
   logic             reset_rq;
   tape_out_t        tape;
   logic             overlap_err;

   // Reference images, same bytes as in the memory model
   logic [7:0] pack_img [0:PACK_MAX-1];
   logic [7:0] cas_img  [0:CAS_MAX-1];

   // Observed DUT activity
   int   ram_addr_seen [$];
   logic [7:0] ram_data_seen [$];
   logic bit_seen [$];
   int   done_seen;
   int   reset_rq_seen;
   int   late_bits;

   int   err_count;
   int   tests_passed;
   int   tests_failed;
   int   limit_cycles;

   msx_cas_buffer #(
      .PACK_BASE (PACK_BASE),
      .CAS_BASE  (CAS_BASE),
      .BIT_DIV   (BIT_DIV)
   ) i_msx_cas_buffer (
      .clk21m    (clk21m),
      .rst       (rst),
      .dl_start  (dl_start),
      .dl_len    (dl_len),
      .play      (play),
      .rewind    (rewind),
      .cas_len   (cas_len),
      .mem_req   (mem_req),
      .mem_rsp   (mem_rsp),
      .ram_wr    (ram_wr),
      .load_done (load_done),
      .reset_rq  (reset_rq),
      .tape      (tape)
   );

   buffer_mem_model #(
      .MAX_LAT (6)
   ) i_buffer_mem_model (
      .clk21m      (clk21m),
      .rst         (rst),
      .req         (mem_req),
      .rsp         (mem_rsp),
      .overlap_err (overlap_err)
   );

   initial begin
      clk21m = 1'b0;
      forever #5 clk21m = ~clk21m;
   end

   // ====================
   // Monitor
   // ====================
   always @(posedge clk21m) begin
      if (!rst) begin
         if (ram_wr.we) begin
            ram_addr_seen.push_back(int'(ram_wr.addr));
            ram_data_seen.push_back(ram_wr.data);
         end
         if (load_done) done_seen++;
         if (reset_rq) reset_rq_seen++;
         if (tape.bit_valid) begin
            bit_seen.push_back(tape.bit_val);
            if (tape.end_of_tape) late_bits++;
         end
      end
   end

   // Watchdog, limit known once the test lengths are drawn
   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk21m);
      $display("Watchdog timeout after %0d cycles, a test never finished", limit_cycles);
      $display("Simulation failed");
      $finish;
   end

   // ====================
   // Helpers
   // ====================
   task automatic step_cycle();
      @(posedge clk21m);
      #1;
   endtask

   task automatic expect_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic expect_true(input logic cond, input string msg);
      assert (cond) else begin
         $display("ERROR at %0t: %s", $time, msg);
         err_count++;
      end
   endtask

   // Model tape bit k, MSB first within each byte
   function automatic logic model_bit(input int k);
      return cas_img[k / 8][7 - (k % 8)];
   endfunction

   task automatic start_pack(input int len);
      ram_addr_seen.delete();
      ram_data_seen.delete();
      done_seen     = 0;
      reset_rq_seen = 0;
      dl_len   = LEN_W'(len);
      dl_start = 1'b1;
      step_cycle();
      dl_start = 1'b0;
   endtask

   // One cycle of rewind, bits seen so far belong to the old stream
   task automatic rewind_tape();
      rewind = 1'b1;
      step_cycle();
      rewind = 1'b0;
      bit_seen.delete();
      late_bits = 0;
   endtask

   task automatic wait_load_done();
      while (done_seen == 0) step_cycle();
      // A few extra cycles to catch a second pulse
      repeat (8) step_cycle();
   endtask

   task automatic wait_tape_end();
      while (!tape.end_of_tape) step_cycle();
      repeat (4 * BIT_DIV) step_cycle();
   endtask

   task automatic check_pack_copy(input int len);
      int i;
      expect_equal("RAM write count", ram_addr_seen.size(), len);
      for (i = 0; i < ram_addr_seen.size() && i < len; i++) begin
         expect_equal($sformatf("RAM write %0d addr", i), ram_addr_seen[i], i);
         expect_equal($sformatf("RAM write %0d data", i), ram_data_seen[i], pack_img[i]);
      end
      expect_equal("load_done pulses", done_seen, 1);
      expect_equal("reset_rq pulses", reset_rq_seen, 1);
   endtask

   task automatic check_tape_prefix();
      int k;
      for (k = 0; k < bit_seen.size(); k++) begin
         expect_equal($sformatf("tape bit %0d", k), bit_seen[k], model_bit(k));
      end
   endtask

   task automatic check_tape_stream(input int len);
      expect_equal("tape bit count", bit_seen.size(), len * 8);
      expect_equal("bits during end of tape", late_bits, 0);
      expect_true(tape.end_of_tape, "end_of_tape is not high after the last bit");
      check_tape_prefix();
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      expect_true(!overlap_err, "buffer memory saw a read while another was outstanding");
      if (err_count == errs_before) begin
         tests_passed++;
         $display("Test %0d %s: PASS", num, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: FAIL with %0d errors", num, name, err_count - errs_before);
      end
   endtask

   // ====================
   // Main sequence
   // ====================
   initial begin
      int i;
      int errs;
      int dl2;
      int cas3;
      int dl4;
      int cas4;
      int cas5;
      int cas6;
      int run;
      int held;
      int c;
      int stop_at;

      clk21m_init: begin
         rst      = 1'b1;
         dl_start = 1'b0;
         dl_len   = '0;
         play     = 1'b0;
         rewind   = 1'b0;
         cas_len  = '0;
      end
      err_count     = 0;
      tests_passed  = 0;
      tests_failed  = 0;
      done_seen     = 0;
      reset_rq_seen = 0;
      late_bits     = 0;
      limit_cycles  = 0;

      void'($urandom(32'h3d2b422a));

      // Random images, mirrored into the buffer memory
      for (i = 0; i < PACK_MAX; i++) begin
         pack_img[i] = 8'($urandom);
         i_buffer_mem_model.load_byte(PACK_BASE + BUF_ADDR_W'(i), pack_img[i]);
      end
      for (i = 0; i < CAS_MAX; i++) begin
         cas_img[i] = 8'($urandom);
         i_buffer_mem_model.load_byte(CAS_BASE + BUF_ADDR_W'(i), cas_img[i]);
      end

      dl2  = $urandom_range(40, 8);
      cas3 = $urandom_range(12, 4);
      dl4  = $urandom_range(40, 8);
      cas4 = $urandom_range(12, 4);
      cas5 = $urandom_range(12, 4);
      cas6 = $urandom_range(12, 6);
      // Pauses and the partial play before rewind count double
      limit_cycles = (dl2 + cas3 + dl4 + cas4 + 2 * cas5 + 2 * cas6) * CYC_PER_BYTE + 1000;

      repeat (4) @(posedge clk21m);
      #1;
      rst = 1'b0;

      // Idle outputs after reset
      errs = err_count;
      repeat (40) begin
         step_cycle();
         expect_equal("mem_req.rd while idle", mem_req.rd, 0);
         expect_equal("ram_wr.we while idle", ram_wr.we, 0);
         expect_equal("load_done while idle", load_done, 0);
         expect_equal("reset_rq while idle", reset_rq, 0);
         expect_equal("bit_valid while idle", tape.bit_valid, 0);
         expect_equal("end_of_tape while idle", tape.end_of_tape, 0);
      end
      report_test(1, "idle after reset", errs);

      // Pack copy alone
      errs = err_count;
      start_pack(dl2);
      wait_load_done();
      check_pack_copy(dl2);
      report_test(2, "pack copy", errs);

      // Tape played to the end
      errs = err_count;
      cas_len = LEN_W'(cas3);
      rewind_tape();
      play = 1'b1;
      wait_tape_end();
      check_tape_stream(cas3);
      play = 1'b0;
      report_test(3, "tape play", errs);

      // Pack copy started while the tape plays
      errs = err_count;
      cas_len = LEN_W'(cas4);
      rewind_tape();
      play = 1'b1;
      repeat ($urandom_range(100, 20)) step_cycle();
      start_pack(dl4);
      wait_load_done();
      wait_tape_end();
      check_pack_copy(dl4);
      check_tape_stream(cas4);
      play = 1'b0;
      report_test(4, "pack copy during tape", errs);

      // Random pauses
      errs = err_count;
      cas_len = LEN_W'(cas5);
      rewind_tape();
      play = 1'b1;
      while (!tape.end_of_tape) begin
         run = $urandom_range(60, 20);
         for (c = 0; c < run && !tape.end_of_tape; c++) step_cycle();
         if (!tape.end_of_tape) begin
            play = 1'b0;
            // Bit from the last tick before the pause may still land
            step_cycle();
            held = bit_seen.size();
            repeat ($urandom_range(16, 4)) step_cycle();
            expect_true(bit_seen.size() == held, "a tape bit came out while play was low");
            play = 1'b1;
         end
      end
      repeat (4 * BIT_DIV) step_cycle();
      check_tape_stream(cas5);
      play = 1'b0;
      report_test(5, "pause and resume", errs);

      // Rewind in the middle of the tape
      errs = err_count;
      cas_len = LEN_W'(cas6);
      rewind_tape();
      play = 1'b1;
      stop_at = $urandom_range(cas6 * 8 - 4, 4);
      while (bit_seen.size() < stop_at) step_cycle();
      check_tape_prefix();
      rewind_tape();
      wait_tape_end();
      check_tape_stream(cas6);
      play = 1'b0;
      report_test(6, "rewind mid-tape", errs);

      $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && err_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- msx_cas_buffer.f
design/msx_buf_pkg.sv
design/pack_loader.sv
design/cas_player.sv
design/buffer_arbiter.sv
design/msx_cas_buffer.sv
dv/buffer_mem_model.sv
dv/msx_cas_buffer_tb.sv
